/* aes_dec.f */
+incdir+.
aes_dec_pkg.sv
key_expander.sv
block_fifo.sv
inv_cipher_core.sv
aes_dec_top.sv
aes_dec_asserts.sv
aes_dec_tb.sv

/* aes_dec_asserts.sv */
/*
 * Protocol assertions bound into aes_dec_top.
 * Occupancy is tracked here from in_valid and the internal pop.
 */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_asserts #(
	parameter int FIFO_DEPTH = aes_dec_pkg::DEFAULT_FIFO_DEPTH
) (
	input logic CLK,
	input logic RESET,
	input logic key_load,
	input logic key_ready,
	input logic in_valid,
	input logic pop,
	input logic out_valid
);
	int occupancy;

	always_ff @(posedge CLK)
	begin
		if (RESET)
			occupancy <= 0;
		else
			occupancy <= occupancy + (in_valid ? 1 : 0) - (pop ? 1 : 0);
	end

	a_no_overflow: assert property (@(posedge CLK) disable iff (RESET)
		in_valid |-> (occupancy < FIFO_DEPTH))
		else $error("block pushed into a full buffer");

	a_single_pulse: assert property (@(posedge CLK) disable iff (RESET)
		out_valid |=> !out_valid)
		else $error("out_valid high for two cycles");

	a_key_latency: assert property (@(posedge CLK) disable iff (RESET)
		key_load |-> ##11 $rose(key_ready))
		else $error("key_ready did not rise 11 cycles after key_load");

endmodule

bind aes_dec_top aes_dec_asserts #(
	.FIFO_DEPTH (FIFO_DEPTH)
) aes_dec_asserts_inst (
	.CLK       (CLK),
	.RESET     (RESET),
	.key_load  (key_load),
	.key_ready (key_ready),
	.in_valid  (in_valid),
	.pop       (pop),
	.out_valid (out_valid)
);

`default_nettype wire

/* aes_dec_pkg.sv */
/*
 * Shared types, tables and round functions for the AES-128 decryption engine.
 * Byte 0 of a block is its most significant byte, in FIPS-197 column order.
 */
`default_nettype none

package aes_dec_pkg;

	typedef logic [127:0] block_t;
	typedef logic [31:0]  word_t;
	typedef logic [7:0]   byte_t;
	typedef logic [3:0]   round_t;

	localparam round_t NUM_ROUNDS = 4'd10;
	localparam int DEFAULT_FIFO_DEPTH = 4;

	// Entry 0 is the leftmost byte
	localparam logic [0:255][7:0] SBOX = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] INV_SBOX = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// Multiply by x modulo the AES polynomial
	function automatic byte_t xtime(input byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	// Coefficients up to 0x0f are enough for InvMixColumns
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t p;
		byte_t x;
		p = '0;
		x = a;
		for (int i = 0; i < 4; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = xtime(x);
		end
		return p;
	endfunction

	function automatic word_t sub_word(input word_t w);
		return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
	endfunction

	function automatic block_t inv_sub_bytes(input block_t s);
		block_t r;
		for (int i = 0; i < 16; i++)
			r[8*i +: 8] = INV_SBOX[s[8*i +: 8]];
		return r;
	endfunction

	// Row r moves right by r columns
	function automatic block_t inv_shift_rows(input block_t s);
		block_t r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
				r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + 4 - row) % 4) + row) -: 8];
		end
		return r;
	endfunction

	function automatic block_t inv_mix_columns(input block_t s);
		block_t r;
		byte_t a0, a1, a2, a3;
		for (int c = 0; c < 4; c++)
		begin
			a0 = s[127 - 32*c -: 8];
			a1 = s[119 - 32*c -: 8];
			a2 = s[111 - 32*c -: 8];
			a3 = s[103 - 32*c -: 8];
			r[127 - 32*c -: 8] = gf_mul(a0, 8'h0e) ^ gf_mul(a1, 8'h0b) ^
				gf_mul(a2, 8'h0d) ^ gf_mul(a3, 8'h09);
			r[119 - 32*c -: 8] = gf_mul(a0, 8'h09) ^ gf_mul(a1, 8'h0e) ^
				gf_mul(a2, 8'h0b) ^ gf_mul(a3, 8'h0d);
			r[111 - 32*c -: 8] = gf_mul(a0, 8'h0d) ^ gf_mul(a1, 8'h09) ^
				gf_mul(a2, 8'h0e) ^ gf_mul(a3, 8'h0b);
			r[103 - 32*c -: 8] = gf_mul(a0, 8'h0b) ^ gf_mul(a1, 8'h0d) ^
				gf_mul(a2, 8'h09) ^ gf_mul(a3, 8'h0e);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* aes_dec_ref.svh */
/*
 * Testbench reference model of AES-128, built from GF(2^8) arithmetic.
 * Call build_sbox_tables once and load_ref_key before any use.
 */
`ifndef AES_DEC_REF_SVH
`define AES_DEC_REF_SVH

logic [7:0]   ref_sbox_tab [0:255];
logic [7:0]   ref_inv_tab [0:255];
logic [127:0] ref_rk [0:10];

function automatic logic [7:0] ref_gmul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] p;
	logic [7:0] x;
	p = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++)
	begin
		if (b[i])
			p = p ^ x;
		x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	end
	return p;
endfunction

// Inverse as v^254, then the affine map
task automatic build_sbox_tables;
	logic [7:0] inv;
	logic [7:0] s;
	for (int v = 0; v < 256; v++)
	begin
		inv = 8'h01;
		for (int k = 0; k < 254; k++)
			inv = ref_gmul(inv, 8'(v));
		s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]} ^
			{inv[3:0], inv[7:4]} ^ 8'h63;
		ref_sbox_tab[v] = s;
		ref_inv_tab[s] = 8'(v);
	end
endtask

function automatic logic [127:0] ref_sub(input logic [127:0] s, input bit inv);
	logic [127:0] o;
	for (int i = 0; i < 16; i++)
		o[8*i +: 8] = inv ? ref_inv_tab[s[8*i +: 8]] : ref_sbox_tab[s[8*i +: 8]];
	return o;
endfunction

// Byte 4*c+r sits in column c, row r
function automatic logic [127:0] ref_shift(input logic [127:0] s, input bit inv);
	logic [127:0] o;
	int src;
	for (int c = 0; c < 4; c++)
	begin
		for (int r = 0; r < 4; r++)
		begin
			src = inv ? (c + 4 - r) % 4 : (c + r) % 4;
			o[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*src + r) -: 8];
		end
	end
	return o;
endfunction

function automatic logic [127:0] ref_mix(input logic [127:0] s, input bit inv);
	logic [127:0] o;
	logic [7:0]   coef [0:3];
	logic [7:0]   acc;
	coef[0] = inv ? 8'h0e : 8'h02;
	coef[1] = inv ? 8'h0b : 8'h03;
	coef[2] = inv ? 8'h0d : 8'h01;
	coef[3] = inv ? 8'h09 : 8'h01;
	for (int c = 0; c < 4; c++)
	begin
		for (int r = 0; r < 4; r++)
		begin
			acc = 8'h00;
			for (int j = 0; j < 4; j++)
				acc = acc ^ ref_gmul(coef[(j - r + 4) % 4], s[127 - 8*(4*c + j) -: 8]);
			o[127 - 8*(4*c + r) -: 8] = acc;
		end
	end
	return o;
endfunction

task automatic load_ref_key(input logic [127:0] k);
	logic [31:0] w [0:43];
	logic [31:0] t;
	logic [7:0]  rcon;
	rcon = 8'h01;
	for (int i = 0; i < 4; i++)
		w[i] = k[127 - 32*i -: 32];
	for (int i = 4; i < 44; i++)
	begin
		t = w[i-1];
		if (i % 4 == 0)
		begin
			t = {t[23:0], t[31:24]};
			t = {ref_sbox_tab[t[31:24]], ref_sbox_tab[t[23:16]], ref_sbox_tab[t[15:8]],
				ref_sbox_tab[t[7:0]]} ^ {rcon, 24'h000000};
			rcon = ref_gmul(rcon, 8'h02);
		end
		w[i] = w[i-4] ^ t;
	end
	for (int r = 0; r < 11; r++)
		ref_rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
endtask

function automatic logic [127:0] ref_encrypt(input logic [127:0] pt);
	logic [127:0] s;
	s = pt ^ ref_rk[0];
	for (int r = 1; r < 11; r++)
	begin
		s = ref_shift(ref_sub(s, 1'b0), 1'b0);
		if (r < 10)
			s = ref_mix(s, 1'b0);
		s = s ^ ref_rk[r];
	end
	return s;
endfunction

function automatic logic [127:0] ref_decrypt(input logic [127:0] ct);
	logic [127:0] s;
	s = ct ^ ref_rk[10];
	for (int r = 9; r >= 0; r--)
	begin
		s = ref_sub(ref_shift(s, 1'b1), 1'b1) ^ ref_rk[r];
		if (r > 0)
			s = ref_mix(s, 1'b1);
	end
	return s;
endfunction

`endif

/* aes_dec_tb.sv */
/*
 * Testbench for aes_dec_top with a credit-tracking sender.
 * Outputs are sampled on the falling edge, inputs driven on the rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_tb;
	import aes_dec_pkg::*;

	localparam int FIFO_DEPTH = DEFAULT_FIFO_DEPTH;
	localparam int TIMEOUT = 400;
	localparam block_t FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
	localparam block_t FIPS_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	logic   CLK;
	logic   RESET;
	logic   key_load;
	logic   in_valid;
	logic   key_ready;
	logic   credit;
	logic   out_valid;
	block_t key;
	block_t in_block;
	block_t out_block;
	block_t exp_block;
	block_t expected_q [$];
	integer seed;
	int     errors;
	int     blocks_sent;
	int     credits_back;
	int     cycle;
	int     in_cycle;
	int     out_cycle;

	`include "aes_dec_ref.svh"

	aes_dec_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) aes_dec_top_inst (
		.CLK       (CLK),
		.RESET     (RESET),
		.key_load  (key_load),
		.key       (key),
		.key_ready (key_ready),
		.in_valid  (in_valid),
		.in_block  (in_block),
		.credit    (credit),
		.out_valid (out_valid),
		.out_block (out_block)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK)
		cycle <= cycle + 1;

	// Credit monitor and output comparison
	always @(negedge CLK)
	begin
		if (!RESET)
		begin
			if (credit)
				credits_back++;
			if (in_valid)
				in_cycle = cycle;
			// A credit only comes back for a block that was sent
			assert (credits_back <= blocks_sent && blocks_sent - credits_back <= FIFO_DEPTH)
			else
			begin
				errors++;
				$display("error at %0t: %0d credits returned for %0d blocks sent", $time,
					credits_back, blocks_sent);
			end
			if (out_valid)
			begin
				out_cycle = cycle;
				if (expected_q.size() == 0)
				begin
					errors++;
					$display("out_valid at %0t with no block pending", $time);
				end
				else
				begin
					exp_block = expected_q.pop_front();
					assert (out_block == exp_block)
					else
					begin
						errors++;
						$display("error at %0t: out_block %h, expected %h",
							$time, out_block, exp_block);
					end
				end
			end
		end
	end

	function automatic int credits_held();
		return FIFO_DEPTH - blocks_sent + credits_back;
	endfunction

	function automatic block_t random_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	// First look is after key_ready has dropped for the new load
	task automatic wait_key_ready();
		int n;
		n = 0;
		@(negedge CLK);
		while (!key_ready)
		begin
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("key_ready");
			@(negedge CLK);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (expected_q.size() != 0)
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("the output to drain");
		end
	endtask

	task automatic load_key(input block_t k);
		@(posedge CLK);
		key_load <= 1'b1;
		key <= k;
		load_ref_key(k);
		@(posedge CLK);
		key_load <= 1'b0;
		wait_key_ready();
	endtask

	// Leaves in_valid high so that blocks can go back to back
	task automatic send_one(input block_t ct);
		int n;
		n = 0;
		@(posedge CLK);
		while (credits_held() == 0)
		begin
			in_valid <= 1'b0;
			n++;
			if (n > TIMEOUT)
				abort_on_timeout("a credit");
			@(posedge CLK);
		end
		in_valid <= 1'b1;
		in_block <= ct;
		blocks_sent++;
		expected_q.push_back(ref_decrypt(ct));
	endtask

	task automatic end_send();
		@(posedge CLK);
		in_valid <= 1'b0;
	endtask

	task automatic send_random(input int n);
		block_t pt;
		block_t ct;
		for (int i = 0; i < n; i++)
		begin
			pt = random_block();
			ct = ref_encrypt(pt);
			assert (ref_decrypt(ct) == pt)
			else
			begin
				errors++;
				$display("error at %0t: reference round trip failed for %h", $time, pt);
			end
			send_one(ct);
		end
		end_send();
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		RESET <= 1'b1;
		in_valid <= 1'b0;
		key_load <= 1'b0;
		expected_q.delete();
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;
		blocks_sent = 0;
		credits_back = 0;
	endtask

	task automatic check_credits();
		assert (credits_back == blocks_sent)
		else
		begin
			errors++;
			$display("error at %0t: %0d credits for %0d blocks", $time, credits_back,
				blocks_sent);
		end
	endtask

	initial
	begin
		CLK = 1'b0;
		RESET = 1'b1;
		key_load = 1'b0;
		key = '0;
		in_valid = 1'b0;
		in_block = '0;
		seed = 32'he857b2a7;
		errors = 0;
		blocks_sent = 0;
		credits_back = 0;
		cycle = 0;
		in_cycle = 0;
		out_cycle = 0;
		build_sbox_tables();
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;

		// Known vector, also a latency check into an idle engine
		load_key(FIPS_KEY);
		assert (ref_encrypt(FIPS_PT) == FIPS_CT && ref_decrypt(FIPS_CT) == FIPS_PT)
		else
		begin
			errors++;
			$display("error at %0t: reference disagrees with the known vector", $time);
		end
		send_one(FIPS_CT);
		end_send();
		wait_drain();
		assert (out_cycle - in_cycle == 12)
		else
		begin
			errors++;
			$display("error at %0t: latency %0d cycles, expected 12", $time,
				out_cycle - in_cycle);
		end

		send_random(20);
		wait_drain();
		check_credits();

		load_key(random_block());
		send_random(6);
		wait_drain();
		check_credits();

		// Reset with blocks in flight
		send_random(4);
		repeat (6) @(posedge CLK);
		apply_reset();
		repeat (20)
		begin
			@(negedge CLK);
			assert (!out_valid)
			else
			begin
				errors++;
				$display("error at %0t: out_valid high after reset", $time);
			end
		end
		assert (credits_held() == FIFO_DEPTH)
		else
		begin
			errors++;
			$display("error at %0t: %0d credits after reset", $time, credits_held());
		end
		load_key(random_block());
		send_random(5);
		wait_drain();
		check_credits();

		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* aes_dec_top.sv */
/*
 * AES-128 decryption engine with credit-based input and no output stall.
 * Load a key only while the engine is idle and the buffer is empty.
 */
`timescale 1ns/1ps
`default_nettype none

module aes_dec_top #(
	parameter int FIFO_DEPTH = aes_dec_pkg::DEFAULT_FIFO_DEPTH
) (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                key_load,
	input  aes_dec_pkg::block_t key,
	output logic                key_ready,
	input  logic                in_valid,
	input  aes_dec_pkg::block_t in_block,
	output logic                credit,
	output logic                out_valid,
	output aes_dec_pkg::block_t out_block
);
	import aes_dec_pkg::*;

	logic   fifo_empty;
	block_t head_block;
	logic   pop;
	round_t rk_index;
	block_t round_key;

	key_expander key_expander_inst (
		.CLK       (CLK),
		.RESET     (RESET),
		.key_load  (key_load),
		.key       (key),
		.rk_index  (rk_index),
		.round_key (round_key),
		.key_ready (key_ready)
	);

	block_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) block_fifo_inst (
		.CLK        (CLK),
		.RESET      (RESET),
		.in_valid   (in_valid),
		.in_block   (in_block),
		.pop        (pop),
		.head_block (head_block),
		.fifo_empty (fifo_empty),
		.credit     (credit)
	);

	inv_cipher_core inv_cipher_core_inst (
		.CLK        (CLK),
		.RESET      (RESET),
		.fifo_empty (fifo_empty),
		.head_block (head_block),
		.key_ready  (key_ready),
		.round_key  (round_key),
		.pop        (pop),
		.rk_index   (rk_index),
		.out_valid  (out_valid),
		.out_block  (out_block)
	);

endmodule

`default_nettype wire

/* block_fifo.sv */
/*
 * Ciphertext buffer with credit return, FIFO_DEPTH of 2 or more.
 * No full check here; the sender must respect its credits.
 */
`timescale 1ns/1ps
`default_nettype none

module block_fifo #(
	parameter int FIFO_DEPTH = aes_dec_pkg::DEFAULT_FIFO_DEPTH
) (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                in_valid,
	input  aes_dec_pkg::block_t in_block,
	input  logic                pop,
	output aes_dec_pkg::block_t head_block,
	output logic                fifo_empty,
	output logic                credit
);
	import aes_dec_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

	block_t           mem [0:FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Depth need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
	endfunction

	assign head_block = mem[rd_ptr];
	assign fifo_empty = (count == '0);

	always_ff @(posedge CLK)
	begin
		if (in_valid)
			mem[wr_ptr] <= in_block;
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (in_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !in_valid)
				count <= count - 1'b1;
			// Slot is free from this cycle on
			credit <= pop;
		end
	end

endmodule

`default_nettype wire

/* inv_cipher_core.sv */
/*
 * Iterative AES-128 inverse cipher, one round per cycle.
 * out_valid rises 11 cycles after pop; the output cannot be stalled.
 */
`timescale 1ns/1ps
`default_nettype none

module inv_cipher_core (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                fifo_empty,
	input  aes_dec_pkg::block_t head_block,
	input  logic                key_ready,
	input  aes_dec_pkg::block_t round_key,
	output logic                pop,
	output aes_dec_pkg::round_t rk_index,
	output logic                out_valid,
	output aes_dec_pkg::block_t out_block
);
	import aes_dec_pkg::*;

	// IDLE waits for a key, INIT_ADDRK waits for a block with key 10 selected
	typedef enum logic [2:0] {
		IDLE,
		INIT_ADDRK,
		ROUND,
		FINAL,
		DONE_PULSE
	} state_t;

	state_t state;
	state_t next_state;
	round_t round_cnt;
	block_t data;
	block_t shifted;
	block_t subbed;
	block_t keyed;

	// A new block may start while the last result is on the output
	assign pop = ((state == INIT_ADDRK) || (state == DONE_PULSE)) && key_ready && !fifo_empty;
	assign rk_index = round_cnt;
	assign out_valid = (state == DONE_PULSE);
	assign out_block = data;

	assign shifted = inv_shift_rows(data);
	assign subbed = inv_sub_bytes(shifted);
	assign keyed = subbed ^ round_key;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (key_ready)
					next_state = INIT_ADDRK;
			end
			INIT_ADDRK, DONE_PULSE:
			begin
				if (pop)
					next_state = ROUND;
				else if (key_ready)
					next_state = INIT_ADDRK;
				else
					next_state = IDLE;
			end
			ROUND:
			begin
				// Last full round uses key 1
				if (round_cnt == round_t'(1))
					next_state = FINAL;
			end
			FINAL:
				next_state = DONE_PULSE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state <= IDLE;
			round_cnt <= NUM_ROUNDS;
		end
		else
		begin
			state <= next_state;
			if (pop)
				round_cnt <= NUM_ROUNDS - round_t'(1);
			else if (state == ROUND)
				round_cnt <= round_cnt - round_t'(1);
			else if (state == FINAL)
				round_cnt <= NUM_ROUNDS;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (pop)
			data <= head_block ^ round_key;
		else if (state == ROUND)
			data <= inv_mix_columns(keyed);
		else if (state == FINAL)
			data <= keyed;
	end

endmodule

`default_nettype wire

/* key_expander.sv */
/*
 * AES-128 key schedule, one round key per cycle after a capture cycle.
 * key_ready is high 11 cycles after key_load. Only indices 0 to 10 are valid.
 */
`timescale 1ns/1ps
`default_nettype none

module key_expander (
	input  logic                CLK,
	input  logic                RESET,
	input  logic                key_load,
	input  aes_dec_pkg::block_t key,
	input  aes_dec_pkg::round_t rk_index,
	output aes_dec_pkg::block_t round_key,
	output logic                key_ready
);
	import aes_dec_pkg::*;

	block_t round_keys [0:NUM_ROUNDS];
	block_t prev_key;
	word_t  rot_temp;
	word_t  nw0, nw1, nw2, nw3;
	round_t round_cnt;
	byte_t  rcon;
	logic   busy;

	assign prev_key = round_keys[round_cnt - round_t'(1)];
	assign round_key = round_keys[rk_index];

	// RotWord, SubWord and Rcon on the last column
	always_comb
	begin
		rot_temp = sub_word({prev_key[23:0], prev_key[31:24]}) ^ {rcon, 24'h000000};
		nw0 = prev_key[127:96] ^ rot_temp;
		nw1 = prev_key[95:64] ^ nw0;
		nw2 = prev_key[63:32] ^ nw1;
		nw3 = prev_key[31:0] ^ nw2;
	end

	always_ff @(posedge CLK)
	begin
		if (key_load)
			round_keys[0] <= key;
		else if (busy)
			round_keys[round_cnt] <= {nw0, nw1, nw2, nw3};
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			busy <= 1'b0;
			key_ready <= 1'b0;
			round_cnt <= '0;
			rcon <= '0;
		end
		else if (key_load)
		begin
			busy <= 1'b1;
			key_ready <= 1'b0;
			round_cnt <= round_t'(1);
			rcon <= 8'h01;
		end
		else if (busy)
		begin
			rcon <= xtime(rcon);
			if (round_cnt == NUM_ROUNDS)
			begin
				busy <= 1'b0;
				key_ready <= 1'b1;
			end
			else
				round_cnt <= round_cnt + round_t'(1);
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds and runs the AES decryption testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --assert -Wno-fatal --top-module aes_dec_tb -f aes_dec.f -o aes_dec_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/aes_dec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
grep -q "NO ERRORS" sim.log || exit 1
exit 0
